//--- Makefile
TOP := tb_sdram_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | awk '{ print } /STATUS: PASS/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- dv/sdram_model.sv
// behavioral sdram: halfword storage, cas-latency read beats and command timing checks
`timescale 1ns/1ps
`include "sdram_consts.svh"

module sdram_model
  import sdram_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  sdram_pins_t             pins,
  input  logic                    bus_ack,
  output logic [`SDRAM_DQ_W-1:0]  dq_in,
  output int                      errors
);

  localparam int hw_w = `SDRAM_BANK_W + `SDRAM_ROW_W + `SDRAM_COL_W;
  localparam int cl = `SDRAM_CAS_LAT;

  // burst writes, standard mode, cas latency, sequential, burst length code
  localparam logic [`SDRAM_A_W-1:0] mode_expect = {3'b000, 1'b0, 2'b00,
      3'(`SDRAM_CAS_LAT), 1'b0, 3'($clog2(`SDRAM_BURST_LEN))};

  // sparse storage, halfword addressed as {bank, row, col}
  logic [`SDRAM_DQ_W-1:0]   mem [logic [hw_w-1:0]];
  logic [`SDRAM_ROW_W-1:0]  open_row [1 << `SDRAM_BANK_W];
  // read beats waiting to go out, slot 0 drives on the next edge
  logic                     beat_v [cl];
  logic [hw_w-1:0]          beat_a [cl];
  logic                     wr_pend;
  logic [hw_w-1:0]          wr_a;
  logic [hw_w-1:0]          col_adr;
  logic                     is_cmd;
  logic                     init_ok;
  logic                     row_cmd;
  logic                     col_cmd;
  logic                     mode_done;
  int                       init_step;
  // cycles left before the next row-level command is legal
  int                       ready_wait;
  int                       rcd_wait;
  int                       since_ref;
  int                       err_cnt = 0;

  // contents of a location never written, every address bit takes part
  function automatic logic [`SDRAM_DQ_W-1:0] blank_half(logic [hw_w-1:0] h);
    return h[15:0] ^ {h[24:16], h[24:18]} ^ 16'h3c5a;
  endfunction

  function automatic logic [`SDRAM_DQ_W-1:0] read_half(logic [hw_w-1:0] h);
    if (mem.exists(h)) begin
      return mem[h];
    end
    return blank_half(h);
  endfunction

  // power-up order: precharge all, two refreshes, mode load
  function automatic sdram_cmd_e init_cmd(int step);
    case (step)
      0: return cmd_precharge;
      3: return cmd_load_mode;
      default: return cmd_auto_refresh;
    endcase
  endfunction

  // cycles before the next activate, refresh, precharge or mode load
  function automatic int hold_after(sdram_cmd_e cmd);
    case (cmd)
      cmd_precharge: return `SDRAM_T_RP;
      cmd_auto_refresh: return `SDRAM_T_RC;
      cmd_active: return `SDRAM_T_RC;
      cmd_load_mode: return `SDRAM_T_MRD;
      cmd_read: return `SDRAM_BURST_LEN + `SDRAM_T_RP;
      // auto-precharge starts after write recovery of the last beat
      cmd_write: return `SDRAM_BURST_LEN - 1 + `SDRAM_T_WR + `SDRAM_T_RP;
      default: return 0;
    endcase
  endfunction

  assign errors  = err_cnt;
  assign is_cmd  = pins.cke && pins.cmd != cmd_nop && pins.cmd != cmd_deselect;
  assign col_adr = {pins.ba, open_row[pins.ba], pins.a[`SDRAM_COL_W-1:0]};
  assign init_ok = (pins.cmd == init_cmd(init_step));
  assign row_cmd = is_cmd && (pins.cmd inside {cmd_active, cmd_auto_refresh,
                                               cmd_precharge, cmd_load_mode});
  assign col_cmd = is_cmd && (pins.cmd == cmd_read || pins.cmd == cmd_write);

  initial dq_in = '0;

  always @(posedge clk) begin
    int need;
    int left;
    need = is_cmd ? hold_after(pins.cmd) - 1 : 0;
    left = (ready_wait > 0) ? ready_wait - 1 : 0;
    if (reset) begin
      init_step  <= 0;
      ready_wait <= 0;
      rcd_wait   <= 0;
      since_ref  <= 0;
      mode_done  <= 1'b0;
      wr_pend    <= 1'b0;
      dq_in      <= '0;
      for (int i = 0; i < cl; i++) begin
        beat_v[i] <= 1'b0;
      end
    end else begin
      ready_wait <= (need > left) ? need : left;
      if (is_cmd && pins.cmd == cmd_active) begin
        rcd_wait <= `SDRAM_T_RCD - 1;
        open_row[pins.ba] <= pins.a[`SDRAM_ROW_W-1:0];
      end else if (rcd_wait > 0) begin
        rcd_wait <= rcd_wait - 1;
      end
      since_ref <= (is_cmd && pins.cmd == cmd_auto_refresh) ? 1 : since_ref + 1;
      if (is_cmd && init_step < 4) begin
        init_step <= init_step + 1;
      end
      // chip usable once tmrd after the mode load has passed
      if (init_step == 4 && ready_wait == 0) begin
        mode_done <= 1'b1;
      end
      // low halfword comes with the write command, high one a cycle later
      wr_pend <= is_cmd && pins.cmd == cmd_write;
      if (is_cmd && pins.cmd == cmd_write) begin
        mem[col_adr] = pins.dq_out;
        wr_a <= {col_adr[hw_w-1:1], ~col_adr[0]};
      end
      if (wr_pend) begin
        mem[wr_a] = pins.dq_out;
      end
      if (beat_v[0]) begin
        dq_in <= read_half(beat_a[0]);
      end
      for (int i = 0; i < cl - 1; i++) begin
        beat_v[i] <= beat_v[i+1];
        beat_a[i] <= beat_a[i+1];
      end
      beat_v[cl-1] <= 1'b0;
      // data valid cas latency after the edge that took the read
      if (is_cmd && pins.cmd == cmd_read) begin
        beat_v[cl-2] <= 1'b1;
        beat_a[cl-2] <= col_adr;
        beat_v[cl-1] <= 1'b1;
        beat_a[cl-1] <= {col_adr[hw_w-1:1], ~col_adr[0]};
      end
    end
  end

  a_init_order: assert property (
    @(posedge clk) disable iff (reset)
    (is_cmd && init_step < 4) |-> init_ok
  ) else begin
    err_cnt++;
    $display("sdram model: init command out of order at %0t", $time);
  end

  a_init_all_banks: assert property (
    @(posedge clk) disable iff (reset)
    (is_cmd && init_step == 0) |-> pins.a[10]
  ) else begin
    err_cnt++;
    $display("sdram model: init precharge left a10 low at %0t", $time);
  end

  a_mode_word: assert property (
    @(posedge clk) disable iff (reset)
    (is_cmd && init_step == 3) |-> (pins.a == mode_expect)
  ) else begin
    err_cnt++;
    $display("mismatch at %0t: load-mode word %h, expected %h",
             $time, $sampled(pins.a), mode_expect);
  end

  a_ack_after_init: assert property (
    @(posedge clk) disable iff (reset)
    bus_ack |-> mode_done
  ) else begin
    err_cnt++;
    $display("sdram model: bus ack before the mode register was loaded at %0t", $time);
  end

  // trp, trc and tmrd all fold into one countdown
  a_row_spacing: assert property (
    @(posedge clk) disable iff (reset)
    row_cmd |-> (ready_wait == 0)
  ) else begin
    err_cnt++;
    $display("sdram model: command came before trp, trc or tmrd had passed at %0t", $time);
  end

  a_rcd_spacing: assert property (
    @(posedge clk) disable iff (reset)
    col_cmd |-> (rcd_wait == 0)
  ) else begin
    err_cnt++;
    $display("sdram model: read or write came before trcd had passed at %0t", $time);
  end

  a_refresh_due: assert property (
    @(posedge clk) disable iff (reset)
    (init_step == 4) |-> (since_ref <= `SDRAM_REFRESH_INTERVAL)
  ) else begin
    err_cnt++;
    $display("sdram model: no auto-refresh within the refresh interval at %0t", $time);
  end

  a_write_drive: assert property (
    @(posedge clk) disable iff (reset)
    ((is_cmd && pins.cmd == cmd_write) || wr_pend) |-> (pins.dq_oe && pins.dqm == 2'b00)
  ) else begin
    err_cnt++;
    $display("sdram model: write beat without the data bus driven at %0t", $time);
  end

endmodule

//--- dv/tb_sdram_subsys.sv
// sdram subsystem testbench: random wishbone traffic against a behavioral sdram
`timescale 1ns/1ps
`include "sdram_consts.svh"

module tb_sdram_subsys
  import sdram_pkg::*;
();

  localparam int clk_period = 10;
  localparam int n_words = 32;
  // extra reads of never written words check the halfword address split
  localparam int n_fresh = 4;
  localparam int n_access = 2 * n_words + n_fresh;
  localparam int init_cycles = 4 + `SDRAM_T_INIT + `SDRAM_T_RP + 2 * `SDRAM_T_RC + `SDRAM_T_MRD;
  // worst case of 40 cycles per access, refresh included
  localparam int watchdog_cycles = init_cycles + n_access * 40 + 200;

  logic                         clk = 1'b0;
  logic                         reset;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [`SDRAM_WB_ADDR_W-1:0]  wb_adr;
  logic [`SDRAM_WB_DATA_W-1:0]  wb_dat_w;
  logic                         wb_ack;
  logic [`SDRAM_WB_DATA_W-1:0]  wb_dat_r;
  sdram_pins_t                  sdram_pins;
  logic [`SDRAM_DQ_W-1:0]       sdram_dq_in;
  int                           model_errors;

  // access currently on the bus and what it should return
  logic                         cur_we;
  logic [`SDRAM_WB_ADDR_W-1:0]  cur_adr;
  logic [`SDRAM_WB_DATA_W-1:0]  exp_rdata;
  logic                         acc_open;
  logic [`SDRAM_WB_DATA_W-1:0]  ref_mem [logic [`SDRAM_WB_ADDR_W-1:0]];
  logic [`SDRAM_WB_ADDR_W-1:0]  addrs [n_words];
  int                           data_errors = 0;
  int                           proto_errors = 0;
  int                           n_done = 0;

  always #(clk_period / 2) clk = ~clk;

  sdram_subsys_top uut (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .sdram_dq_in (sdram_dq_in),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r),
    .sdram_pins  (sdram_pins)
  );

  sdram_model mem_model (
    .clk     (clk),
    .reset   (reset),
    .pins    (sdram_pins),
    .bus_ack (wb_ack),
    .dq_in   (sdram_dq_in),
    .errors  (model_errors)
  );

  // power-up contents of one halfword in the memory model
  function automatic logic [15:0] fill_half(logic [24:0] hw_adr);
    return hw_adr[15:0] ^ {hw_adr[24:16], hw_adr[24:18]} ^ 16'h3c5a;
  endfunction

  // halfword address is the word address times two, low half at the even one
  function automatic logic [31:0] expect_word(logic [23:0] adr);
    if (ref_mem.exists(adr)) begin
      return ref_mem[adr];
    end
    return {fill_half({adr, 1'b1}), fill_half({adr, 1'b0})};
  endfunction

  // called on a falling edge, returns on the falling edge after the ack was taken
  task automatic bus_access(input logic we, input logic [23:0] adr, input logic [31:0] data);
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = we;
    wb_adr    = adr;
    wb_dat_w  = data;
    cur_we    = we;
    cur_adr   = adr;
    exp_rdata = we ? '0 : expect_word(adr);
    acc_open  = 1'b1;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
    end
    // master samples ack on the coming rising edge
    @(negedge clk);
    acc_open = 1'b0;
    n_done++;
  endtask

  task automatic bus_idle();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [23:0] adr;
    reset     = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    cur_we    = 1'b1;
    cur_adr   = '0;
    exp_rdata = '0;
    acc_open  = 1'b0;
    void'($urandom(127));
    repeat (4) @(negedge clk);
    reset = 1'b0;
    // first write is posted during init and waits out the power-up sequence
    for (int i = 0; i < n_words; i++) begin
      rnd = $urandom();
      adr = rnd[23:0];
      addrs[i] = adr;
      rnd = $urandom();
      bus_access(1'b1, adr, rnd);
      ref_mem[adr] = rnd;
    end
    // read back with no gap, runs well past three refresh intervals
    for (int i = 0; i < n_words; i++) begin
      bus_access(1'b0, addrs[i], '0);
    end
    for (int i = 0; i < n_fresh; i++) begin
      rnd = $urandom();
      bus_access(1'b0, rnd[23:0], '0);
    end
    bus_idle();
    // a late stray ack still has to hit the checks
    repeat (8) @(negedge clk);
    $display("accesses %0d, data errors %0d, protocol errors %0d, memory model errors %0d",
             n_done, data_errors, proto_errors, model_errors);
    if (data_errors == 0 && proto_errors == 0 && model_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, an access never completed", watchdog_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  a_read_data: assert property (
    @(posedge clk) disable iff (reset)
    (wb_ack && !cur_we) |-> (wb_dat_r == exp_rdata)
  ) else begin
    data_errors++;
    $display("mismatch at %0t: read of word %h returned %h, expected %h",
             $time, cur_adr, $sampled(wb_dat_r), exp_rdata);
  end

  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (reset)
    wb_ack |-> (wb_cyc && wb_stb)
  ) else begin
    proto_errors++;
    $display("wishbone ack raised without cyc and stb at %0t", $time);
  end

  a_ack_pulse: assert property (
    @(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack
  ) else begin
    proto_errors++;
    $display("wishbone ack held high for more than one cycle at %0t", $time);
  end

  a_ack_owned: assert property (
    @(posedge clk) disable iff (reset)
    wb_ack |-> acc_open
  ) else begin
    proto_errors++;
    $display("wishbone ack raised with no access outstanding at %0t", $time);
  end

endmodule

//--- filelist.f
+incdir+source
source/sdram_pkg.sv
source/wb_sdram_port.sv
source/sdram_cmd_fsm.sv
source/sdram_rd_capture.sv
source/sdram_subsys_top.sv
dv/sdram_model.sv
dv/tb_sdram_subsys.sv

//--- source/sdram_cmd_fsm.sv
// sdram command sequencer: init, mode load, auto-refresh, activate and read/write
`timescale 1ns/1ps
`include "sdram_consts.svh"

module sdram_cmd_fsm
  import sdram_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  sdram_req_t   req,
  input  logic         req_valid,
  output logic         req_accept,
  output logic         wr_done,
  output logic         rd_issue,
  output sdram_pins_t  pins
);

  localparam int cnt_w = 8;
  localparam int ref_w = $clog2(`SDRAM_REFRESH_INTERVAL + 1);

  // init schedule, values are the cycle before the command shows on the pins
  localparam logic [cnt_w-1:0] pre_at  = cnt_w'(`SDRAM_T_INIT - 1);
  localparam logic [cnt_w-1:0] ref1_at = cnt_w'(`SDRAM_T_INIT + `SDRAM_T_RP - 1);
  localparam logic [cnt_w-1:0] ref2_at = cnt_w'(`SDRAM_T_INIT + `SDRAM_T_RP + `SDRAM_T_RC - 1);
  localparam logic [cnt_w-1:0] lmr_at  =
      cnt_w'(`SDRAM_T_INIT + `SDRAM_T_RP + 2 * `SDRAM_T_RC - 1);

  // last cycle of each timed phase
  localparam logic [cnt_w-1:0] mrd_last  = cnt_w'(`SDRAM_T_MRD - 1);
  localparam logic [cnt_w-1:0] rcd_last  = cnt_w'(`SDRAM_T_RCD - 1);
  localparam logic [cnt_w-1:0] rd_last   = cnt_w'(`SDRAM_CAS_LAT + `SDRAM_BURST_LEN - 1);
  localparam logic [cnt_w-1:0] wr_last   =
      cnt_w'(`SDRAM_BURST_LEN + `SDRAM_T_WR + `SDRAM_T_RP - 1);
  localparam logic [cnt_w-1:0] rc_last   = cnt_w'(`SDRAM_T_RC - 1);
  localparam logic [cnt_w-1:0] beat_last = cnt_w'(`SDRAM_BURST_LEN - 1);

  // due early enough that a full activate plus write still fits in the interval
  localparam logic [ref_w-1:0] refresh_due = ref_w'(`SDRAM_REFRESH_INTERVAL - `SDRAM_T_RCD
      - (`SDRAM_BURST_LEN + `SDRAM_T_WR + `SDRAM_T_RP) - 2);
  localparam logic [ref_w-1:0] refresh_limit = ref_w'(`SDRAM_REFRESH_INTERVAL);

  // nop with cke low right out of reset
  localparam sdram_pins_t reset_pins = '{
    cke: 1'b0, cmd: cmd_nop, ba: '0, a: '0, dq_out: '0, dq_oe: 1'b0, dqm: '0
  };

  typedef enum logic [2:0] {
    st_init, st_mode, st_idle, st_active, st_read, st_write, st_refresh
  } state_e;

  state_e            state;
  state_e            next_state;
  logic [cnt_w-1:0]  wait_cnt;
  logic [ref_w-1:0]  ref_cnt;
  sdram_req_t        req_q;
  sdram_pins_t       next_pins;
  logic              phase_end;
  logic              take_req;
  logic              init_done;

  assign init_done = (state != st_init) && (state != st_mode);

  always_comb begin
    next_state = state;
    phase_end  = 1'b0;
    take_req   = 1'b0;
    next_pins        = reset_pins;
    next_pins.cke    = 1'b1;
    case (state)
      st_init: begin
        // a10 high makes the precharge hit every bank
        if (wait_cnt == pre_at) begin
          next_pins.cmd   = cmd_precharge;
          next_pins.a[10] = 1'b1;
        end
        if (wait_cnt == ref1_at || wait_cnt == ref2_at) begin
          next_pins.cmd = cmd_auto_refresh;
        end
        if (wait_cnt == lmr_at) begin
          next_pins.cmd = cmd_load_mode;
          next_pins.a   = sdram_mode_word;
          next_state    = st_mode;
        end
      end
      st_mode: begin
        if (wait_cnt == mrd_last) begin
          next_state = st_idle;
        end
      end
      st_idle: phase_end = 1'b1;
      st_active: begin
        // column command with auto-precharge after trcd
        if (wait_cnt == rcd_last) begin
          next_state                        = req_q.we ? st_write : st_read;
          next_pins.cmd                     = req_q.we ? cmd_write : cmd_read;
          next_pins.ba                      = req_q.bank;
          next_pins.a[`SDRAM_COL_W-1:0]     = req_q.col;
          next_pins.a[10]                   = 1'b1;
          // low halfword goes out with the write command
          next_pins.dq_out = req_q.wdata[`SDRAM_DQ_W-1:0];
          next_pins.dq_oe  = req_q.we;
        end
      end
      st_read: phase_end = (wait_cnt == rd_last);
      st_write: begin
        // second beat carries the high halfword
        if (wait_cnt < beat_last) begin
          next_pins.dq_out = req_q.wdata[`SDRAM_WB_DATA_W-1 -: `SDRAM_DQ_W];
          next_pins.dq_oe  = 1'b1;
        end
        phase_end = (wait_cnt == wr_last);
      end
      st_refresh: phase_end = (wait_cnt == rc_last);
      default: next_state = st_idle;
    endcase

    // bank is closed here, pick refresh first, then a waiting request
    if (phase_end) begin
      if (ref_cnt >= refresh_due) begin
        next_state    = st_refresh;
        next_pins.cmd = cmd_auto_refresh;
      end else if (req_valid) begin
        take_req      = 1'b1;
        next_state    = st_active;
        next_pins.cmd = cmd_active;
        next_pins.ba  = req.bank;
        next_pins.a   = req.row;
      end else begin
        next_state = st_idle;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_init;
      wait_cnt   <= '0;
      ref_cnt    <= '0;
      pins       <= reset_pins;
      req_accept <= 1'b0;
      wr_done    <= 1'b0;
      rd_issue   <= 1'b0;
    end else begin
      state <= next_state;
      // restart the phase timer on every state change
      wait_cnt <= (next_state != state) ? '0 : wait_cnt + 1'b1;
      // cycles since the last auto-refresh on the pins
      ref_cnt    <= (next_pins.cmd == cmd_auto_refresh) ? '0 : ref_cnt + 1'b1;
      pins       <= next_pins;
      req_accept <= take_req;
      rd_issue   <= (next_pins.cmd == cmd_read);
      // lands on the last write recovery cycle
      wr_done    <= (state == st_write) && (wait_cnt == wr_last - 1'b1);
    end
  end

  // held for the whole activate and column phase
  always_ff @(posedge clk) begin
    if (take_req) begin
      req_q <= req;
    end
  end

  // column command never closer than trcd to the activate before it
  a_rcd_spacing: assert property (
    @(posedge clk) disable iff (reset)
    (pins.cmd == cmd_active) |=>
      (pins.cmd != cmd_read && pins.cmd != cmd_write) [*(`SDRAM_T_RCD - 1)]
  );

  // traffic must not starve refresh once the chip is up
  a_refresh_interval: assert property (
    @(posedge clk) disable iff (reset)
    init_done |-> (ref_cnt < refresh_limit)
  );

endmodule

//--- source/sdram_consts.svh
// sdram constants: bus widths, burst and latency setup, cycle-count timing
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// wishbone side, word addressed
`define SDRAM_WB_ADDR_W 24
`define SDRAM_WB_DATA_W 32

// sdram side, 32M x 16 part
`define SDRAM_A_W 13
`define SDRAM_DQ_W 16
`define SDRAM_COL_W 10
`define SDRAM_ROW_W 13
`define SDRAM_BANK_W 2

// two halfword beats make one bus word
`define SDRAM_CAS_LAT 2
`define SDRAM_BURST_LEN 2

// all timing in clock cycles
// power-up wait is shortened for simulation
`define SDRAM_T_INIT 20
`define SDRAM_T_MRD 2
`define SDRAM_T_RCD 2
`define SDRAM_T_RP 2
`define SDRAM_T_RC 6
`define SDRAM_T_WR 2
// longest allowed gap between two auto-refresh commands
`define SDRAM_REFRESH_INTERVAL 100

`endif

//--- source/sdram_pkg.sv
// sdram types: command encoding, request, pin bundle and read return
`include "sdram_consts.svh"

package sdram_pkg;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    cmd_load_mode    = 4'b0000,
    cmd_auto_refresh = 4'b0001,
    cmd_precharge    = 4'b0010,
    cmd_active       = 4'b0011,
    cmd_write        = 4'b0100,
    cmd_read         = 4'b0101,
    cmd_nop          = 4'b0111,
    cmd_deselect     = 4'b1111
  } sdram_cmd_e;

  // one word access, address already in halfword units
  typedef struct packed {
    logic                         we;
    logic [`SDRAM_BANK_W-1:0]     bank;
    logic [`SDRAM_ROW_W-1:0]      row;
    logic [`SDRAM_COL_W-1:0]      col;
    logic [`SDRAM_WB_DATA_W-1:0]  wdata;
  } sdram_req_t;

  // everything the controller drives toward the chip
  typedef struct packed {
    logic                      cke;
    sdram_cmd_e                cmd;
    logic [`SDRAM_BANK_W-1:0]  ba;
    logic [`SDRAM_A_W-1:0]     a;
    logic [`SDRAM_DQ_W-1:0]    dq_out;
    logic                      dq_oe;
    // {dqmh, dqml}
    logic [1:0]                dqm;
  } sdram_pins_t;

  // packed read word, valid is a single-cycle strobe
  typedef struct packed {
    logic                         valid;
    logic [`SDRAM_WB_DATA_W-1:0]  data;
  } sdram_rd_t;

  // write burst mode, reserved, cas latency, sequential, burst length 2
  localparam logic [`SDRAM_A_W-1:0] sdram_mode_word = 13'b000_0_00_010_0_001;

endpackage

//--- source/sdram_rd_capture.sv
// read capture: takes the two halfword beats after cas latency and packs a word
`timescale 1ns/1ps
`include "sdram_consts.svh"

module sdram_rd_capture
  import sdram_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    rd_issue,
  input  logic [`SDRAM_DQ_W-1:0]  dq_in,
  output sdram_rd_t               rd_ret
);

  localparam int cl = `SDRAM_CAS_LAT;

  // bit k set means a read command went out k+1 cycles ago
  logic [cl:0]                    issue_pipe;
  logic [`SDRAM_DQ_W-1:0]         low_beat;
  logic                           ret_valid;
  logic [`SDRAM_WB_DATA_W-1:0]    ret_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      issue_pipe <= '0;
      ret_valid  <= 1'b0;
    end else begin
      issue_pipe <= {issue_pipe[cl-1:0], rd_issue};
      // word is complete once the high beat is taken
      ret_valid  <= issue_pipe[cl];
    end
  end

  always_ff @(posedge clk) begin
    // first beat, cas latency after the read command
    if (issue_pipe[cl-1]) begin
      low_beat <= dq_in;
    end
    // second beat, low halfword sits at the even address
    if (issue_pipe[cl]) begin
      ret_data <= {dq_in, low_beat};
    end
  end

  assign rd_ret = '{valid: ret_valid, data: ret_data};

  // each read yields exactly one strobe even with reads back to back
  a_valid_pulse: assert property (
    @(posedge clk) disable iff (reset)
    ret_valid |=> !ret_valid
  );

endmodule

//--- source/sdram_subsys_top.sv
// sdram subsystem top: wishbone port, command sequencer and read capture
`timescale 1ns/1ps
`include "sdram_consts.svh"

module sdram_subsys_top
  import sdram_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [`SDRAM_WB_ADDR_W-1:0]  wb_adr,
  input  logic [`SDRAM_WB_DATA_W-1:0]  wb_dat_w,
  input  logic [`SDRAM_DQ_W-1:0]       sdram_dq_in,
  output logic                         wb_ack,
  output logic [`SDRAM_WB_DATA_W-1:0]  wb_dat_r,
  output sdram_pins_t                  sdram_pins
);

  // port to sequencer
  sdram_req_t  req;
  logic        req_valid;
  logic        req_accept;
  logic        wr_done;
  // sequencer to capture, capture back to port
  logic        rd_issue;
  sdram_rd_t   rd_ret;

  wb_sdram_port u_port (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .req_accept (req_accept),
    .wr_done    (wr_done),
    .rd_ret     (rd_ret),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .req        (req),
    .req_valid  (req_valid)
  );

  sdram_cmd_fsm u_cmd (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_accept (req_accept),
    .wr_done    (wr_done),
    .rd_issue   (rd_issue),
    .pins       (sdram_pins)
  );

  sdram_rd_capture u_capture (
    .clk      (clk),
    .reset    (reset),
    .rd_issue (rd_issue),
    .dq_in    (sdram_dq_in),
    .rd_ret   (rd_ret)
  );

endmodule

//--- source/wb_sdram_port.sv
// wishbone classic slave port: one sdram request per bus cycle, ack on completion
`timescale 1ns/1ps
`include "sdram_consts.svh"

module wb_sdram_port
  import sdram_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [`SDRAM_WB_ADDR_W-1:0]  wb_adr,
  input  logic [`SDRAM_WB_DATA_W-1:0]  wb_dat_w,
  input  logic                         req_accept,
  input  logic                         wr_done,
  input  sdram_rd_t                    rd_ret,
  output logic                         wb_ack,
  output logic [`SDRAM_WB_DATA_W-1:0]  wb_dat_r,
  output sdram_req_t                   req,
  output logic                         req_valid
);

  // an access is in flight from request latch until ack
  logic busy;
  logic start;
  logic done;

  // new cycle is only taken while idle
  assign start = wb_cyc && wb_stb && !busy;

  // completion depends on direction of the held request
  assign done = busy && !wb_ack && (req.we ? wr_done : rd_ret.valid);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      req_valid <= 1'b0;
      wb_ack    <= 1'b0;
    end else begin
      // ack is a single pulse
      wb_ack <= done;
      if (start) begin
        busy      <= 1'b1;
        req_valid <= 1'b1;
      end else if (req_accept) begin
        req_valid <= 1'b0;
      end
      // free again once the master has seen ack
      if (wb_ack) begin
        busy <= 1'b0;
      end
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (start) begin
      req.we <= wb_we;
      // word address times two gives the halfword address
      {req.bank, req.row, req.col} <= {wb_adr, 1'b0};
      req.wdata <= wb_dat_w;
    end
  end

  // hold the returned word for the ack cycle
  always_ff @(posedge clk) begin
    if (rd_ret.valid) begin
      wb_dat_r <= rd_ret.data;
    end
  end

  // an ack outside a live cycle would be seen by no master
  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (reset)
    wb_ack |-> (wb_cyc && wb_stb)
  );

endmodule
